//--- ipod_defines.svh
`ifndef IPOD_DEFINES_SVH
`define IPOD_DEFINES_SVH

// ==================================================
// Sample rate divisor
// ==================================================
`define DIV_W       24
`define DIV_DEFAULT 40
`define DIV_STEP    8
`define DIV_MIN     16
`define DIV_MAX     96

// Clock cycles between auto-repeat events of a held key
`define KEY_REPEAT  64

// ==================================================
// Flash port and level meter
// ==================================================
`define FLASH_AW    23
`define FLASH_DW    32

// Samples per peak window
`define VOL_WINDOW  8

`endif

//--- ipod_pkg.sv
package ipod_pkg;

  // Push keys, active-high levels
  typedef struct packed {
    logic up;
    logic down;
    logic rst;
  } key_t;

  // Playback switches
  typedef struct packed {
    logic pause;
    logic reverse;
  } play_sw_t;

  // Signed 8-bit audio sample
  typedef logic signed [7:0] sample_t;

  // Active-low segments, bit 0 is segment a, bit 6 is segment g
  typedef logic [6:0] seg_t;

  // Blank digit pattern
  localparam seg_t SEG_BLANK = 7'h7f;

  // Byte lanes per flash word
  localparam int BYTES_PER_WORD = 4;

endpackage

//--- input_sync.sv
`timescale 1ns/1ps

module input_sync #(
  parameter type T = logic
) (
  input  logic CLK_50M,
  input  logic arst_n,
  input  T     async_in,
  output T     sync_out
);

  T meta_q;
  T sync_q;

  // Two flop stages, first one may go metastable
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      meta_q <= '0;
      sync_q <= '0;
    end
    else
    begin
      meta_q <= async_in;
      sync_q <= meta_q;
    end
  end

  assign sync_out = sync_q;

endmodule

//--- speed_ctrl.sv
`timescale 1ns/1ps
`include "ipod_defines.svh"

module speed_ctrl (
  input  logic                CLK_50M,
  input  logic                arst_n,
  input  ipod_pkg::key_t      keys,
  output logic [`DIV_W-1:0]   divisor,
  output logic                tick
);

  localparam int RPT_W = $clog2(`KEY_REPEAT);
  localparam logic [RPT_W-1:0] RPT_LAST = RPT_W'(`KEY_REPEAT - 1);

  localparam logic [`DIV_W-1:0] DIV_DEF  = `DIV_W'(`DIV_DEFAULT);
  localparam logic [`DIV_W-1:0] DIV_LO   = `DIV_W'(`DIV_MIN);
  localparam logic [`DIV_W-1:0] DIV_HI   = `DIV_W'(`DIV_MAX);
  localparam logic [`DIV_W-1:0] DIV_STEP = `DIV_W'(`DIV_STEP);

  // Bit positions in the key vector
  localparam int K_UP   = 2;
  localparam int K_DOWN = 1;
  localparam int K_RST  = 0;

  logic [2:0]       key_vec;
  logic [2:0]       key_q;
  logic [2:0]       key_evt;
  logic [RPT_W-1:0] rpt_cnt [3];
  logic [`DIV_W-1:0] strobe_cnt;

  assign key_vec = {keys.up, keys.down, keys.rst};

  // ==================================================
  // Edge and auto-repeat detection
  // ==================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      key_q   <= '0;
      key_evt <= '0;
      for (int i = 0; i < 3; i++)
        rpt_cnt[i] <= '0;
    end
    else
    begin
      key_q <= key_vec;
      for (int i = 0; i < 3; i++)
      begin
        key_evt[i] <= 1'b0;
        if (key_vec[i] && !key_q[i])
        begin
          // Fresh press, restart the repeat interval
          key_evt[i] <= 1'b1;
          rpt_cnt[i] <= '0;
        end
        else if (key_vec[i])
        begin
          if (rpt_cnt[i] == RPT_LAST)
          begin
            key_evt[i] <= 1'b1;
            rpt_cnt[i] <= '0;
          end
          else
            rpt_cnt[i] <= rpt_cnt[i] + 1'b1;
        end
        else
          rpt_cnt[i] <= '0;
      end
    end
  end

  // Divisor register, up means faster playback
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      divisor <= DIV_DEF;
    else if (key_evt[K_RST])
      divisor <= DIV_DEF;
    else if (key_evt[K_UP])
      divisor <= (divisor <= DIV_LO + DIV_STEP) ? DIV_LO : divisor - DIV_STEP;
    else if (key_evt[K_DOWN])
      divisor <= (divisor >= DIV_HI - DIV_STEP) ? DIV_HI : divisor + DIV_STEP;
  end

  // ==================================================
  // Sample strobe, reloads the divisor on each tick
  // ==================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      strobe_cnt <= DIV_DEF - 1'b1;
      tick       <= 1'b0;
    end
    else
    begin
      tick <= (strobe_cnt == '0);
      if (strobe_cnt == '0)
        strobe_cnt <= divisor - 1'b1;
      else
        strobe_cnt <= strobe_cnt - 1'b1;
    end
  end

endmodule

//--- flash_reader.sv
`timescale 1ns/1ps
`include "ipod_defines.svh"

module flash_reader (
  input  logic                  CLK_50M,
  input  logic                  arst_n,
  input  logic                  tick,
  input  ipod_pkg::play_sw_t    play_sw,
  output logic                  flash_read,
  output logic [`FLASH_AW-1:0]  flash_addr,
  input  logic                  flash_wait,
  input  logic [`FLASH_DW-1:0]  flash_rdata,
  input  logic                  flash_rvalid,
  output ipod_pkg::sample_t     sample,
  output logic                  sample_valid
);

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_DATA} fetch_state_t;

  fetch_state_t          state;
  logic [`FLASH_AW+1:0]  idx;
  logic [`FLASH_AW+1:0]  idx_next;
  logic [`FLASH_AW-1:0]  word_idx;
  logic [`FLASH_DW-1:0]  held_word;
  logic [`FLASH_AW-1:0]  held_addr;
  logic                  held_ok;
  logic                  hit;
  logic                  pend;
  logic                  tick_go;

  // Byte 0 is the least significant lane
  function automatic ipod_pkg::sample_t pick_byte(input logic [`FLASH_DW-1:0] word,
                                                  input logic [1:0]           sel);
    return ipod_pkg::sample_t'(word[8*sel +: 8]);
  endfunction

  assign word_idx = idx[`FLASH_AW+1:2];
  assign hit      = held_ok && (held_addr == word_idx);
  assign tick_go  = tick && !play_sw.pause;
  assign idx_next = play_sw.reverse ? idx - 1'b1 : idx + 1'b1;

  assign flash_read = (state == S_REQ);

  // ==================================================
  // Word fetch, one request in flight
  // ==================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state      <= S_IDLE;
      flash_addr <= '0;
    end
    else
    begin
      case (state)
        S_IDLE:
          if (!hit)
          begin
            flash_addr <= word_idx;
            state      <= S_REQ;
          end
        S_REQ:
          if (!flash_wait)
            state <= S_DATA;
        S_DATA:
          if (flash_rvalid)
            state <= S_IDLE;
        default:
          state <= S_IDLE;
      endcase
    end
  end

  // Returned word and its address
  always_ff @(posedge CLK_50M)
  begin
    if (flash_rvalid)
    begin
      held_word <= flash_rdata;
      held_addr <= flash_addr;
    end
  end

  // ==================================================
  // Byte sequencer
  // ==================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      idx          <= '0;
      held_ok      <= 1'b0;
      pend         <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      if (flash_rvalid)
        held_ok <= 1'b1;
      if (flash_rvalid && (pend || tick_go))
      begin
        // Play straight from the bus, one cycle after rvalid
        sample_valid <= 1'b1;
        idx          <= idx_next;
        pend         <= 1'b0;
      end
      else if (tick_go && hit)
      begin
        sample_valid <= 1'b1;
        idx          <= idx_next;
      end
      else if (tick_go)
        pend <= 1'b1;
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (flash_rvalid && (pend || tick_go))
      sample <= pick_byte(flash_rdata, idx[1:0]);
    else if (tick_go && hit)
      sample <= pick_byte(held_word, idx[1:0]);
  end

endmodule

//--- volume_meter.sv
`timescale 1ns/1ps
`include "ipod_defines.svh"

module volume_meter (
  input  logic              CLK_50M,
  input  logic              arst_n,
  input  ipod_pkg::sample_t sample,
  input  logic              sample_valid,
  output logic [7:0]        led
);

  localparam int CNT_W = $clog2(`VOL_WINDOW);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`VOL_WINDOW - 1);

  logic [CNT_W-1:0] win_cnt;
  logic [7:0]       peak;
  logic [7:0]       mag;
  logic [7:0]       peak_next;
  logic [8:0]       bar;

  // -128 wraps to 8'h80, read as unsigned 128
  assign mag       = sample[7] ? (~sample + 1'b1) : sample;
  assign peak_next = (mag > peak) ? mag : peak;

  // Thermometer bar, one lit LED per 16 of peak
  assign bar = (9'd1 << peak_next[7:4]) - 9'd1;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      win_cnt <= '0;
      peak    <= '0;
      led     <= '0;
    end
    else if (sample_valid)
    begin
      if (win_cnt == CNT_LAST)
      begin
        led     <= bar[7:0];
        peak    <= '0;
        win_cnt <= '0;
      end
      else
      begin
        peak    <= peak_next;
        win_cnt <= win_cnt + 1'b1;
      end
    end
  end

endmodule

//--- hex_display.sv
`timescale 1ns/1ps
`include "ipod_defines.svh"

module hex_display (
  input  logic [`DIV_W-1:0] divisor,
  output ipod_pkg::seg_t    hex0,
  output ipod_pkg::seg_t    hex1,
  output ipod_pkg::seg_t    hex2,
  output ipod_pkg::seg_t    hex3,
  output ipod_pkg::seg_t    hex4,
  output ipod_pkg::seg_t    hex5
);

  // Active-low patterns, segment g in bit 6
  function automatic ipod_pkg::seg_t seg_decode(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'ha: return 7'b0001000;
      4'hb: return 7'b0000011;
      4'hc: return 7'b1000110;
      4'hd: return 7'b0100001;
      4'he: return 7'b0000110;
      4'hf: return 7'b0001110;
      default: return ipod_pkg::SEG_BLANK;
    endcase
  endfunction

  // Lowest nibble on the rightmost digit
  assign hex0 = seg_decode(divisor[3:0]);
  assign hex1 = seg_decode(divisor[7:4]);
  assign hex2 = seg_decode(divisor[11:8]);
  assign hex3 = seg_decode(divisor[15:12]);
  assign hex4 = seg_decode(divisor[19:16]);
  assign hex5 = seg_decode(divisor[23:20]);

endmodule

//--- ipod_top.sv
`timescale 1ns/1ps
`include "ipod_defines.svh"

module ipod_top (
  input  logic                  CLK_50M,
  input  logic                  arst_n,
  input  ipod_pkg::key_t        keys,
  input  ipod_pkg::play_sw_t    play_sw,
  output logic                  flash_read,
  output logic [`FLASH_AW-1:0]  flash_addr,
  input  logic                  flash_wait,
  input  logic [`FLASH_DW-1:0]  flash_rdata,
  input  logic                  flash_rvalid,
  output ipod_pkg::sample_t     sample,
  output logic                  sample_valid,
  output logic [7:0]            led,
  output ipod_pkg::seg_t        hex0,
  output ipod_pkg::seg_t        hex1,
  output ipod_pkg::seg_t        hex2,
  output ipod_pkg::seg_t        hex3,
  output ipod_pkg::seg_t        hex4,
  output ipod_pkg::seg_t        hex5
);

  ipod_pkg::key_t     keys_s;
  ipod_pkg::play_sw_t play_sw_s;
  logic [`DIV_W-1:0]  divisor;
  logic               tick;

  // ==================================================
  // Input synchronisers
  // ==================================================
  input_sync #(.T(ipod_pkg::key_t)) u_key_sync (
    .CLK_50M  (CLK_50M),
    .arst_n   (arst_n),
    .async_in (keys),
    .sync_out (keys_s)
  );

  input_sync #(.T(ipod_pkg::play_sw_t)) u_sw_sync (
    .CLK_50M  (CLK_50M),
    .arst_n   (arst_n),
    .async_in (play_sw),
    .sync_out (play_sw_s)
  );

  // ==================================================
  // Playback path
  // ==================================================
  speed_ctrl u_speed_ctrl (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .keys    (keys_s),
    .divisor (divisor),
    .tick    (tick)
  );

  flash_reader u_flash_reader (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .tick         (tick),
    .play_sw      (play_sw_s),
    .flash_read   (flash_read),
    .flash_addr   (flash_addr),
    .flash_wait   (flash_wait),
    .flash_rdata  (flash_rdata),
    .flash_rvalid (flash_rvalid),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  // Meter and display
  volume_meter u_volume_meter (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .sample       (sample),
    .sample_valid (sample_valid),
    .led          (led)
  );

  hex_display u_hex_display (
    .divisor (divisor),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

endmodule

//--- ipod_chk.sv
`timescale 1ns/1ps
`include "ipod_defines.svh"

module ipod_chk (
  input logic                 CLK_50M,
  input logic                 arst_n,
  input logic                 flash_read,
  input logic [`FLASH_AW-1:0] flash_addr,
  input logic                 flash_wait,
  input logic                 flash_rvalid,
  input logic                 sample_valid
);

  int   fail_cnt = 0;
  logic outstanding;

  // Set on acceptance, cleared by the data beat
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      outstanding <= 1'b0;
    else if (flash_read && !flash_wait)
      outstanding <= 1'b1;
    else if (flash_rvalid)
      outstanding <= 1'b0;
  end

  a_req_stable: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    (flash_read && flash_wait) |=> (flash_read && $stable(flash_addr)))
  else
  begin
    $error("flash request changed while flash_wait was high");
    fail_cnt++;
  end

  a_one_outstanding: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    outstanding |-> !flash_read)
  else
  begin
    $error("new flash request while data still outstanding");
    fail_cnt++;
  end

  a_valid_pulse: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    sample_valid |=> !sample_valid)
  else
  begin
    $error("sample_valid high on two cycles in a row");
    fail_cnt++;
  end

endmodule

bind flash_reader ipod_chk u_chk (
  .CLK_50M      (CLK_50M),
  .arst_n       (arst_n),
  .flash_read   (flash_read),
  .flash_addr   (flash_addr),
  .flash_wait   (flash_wait),
  .flash_rvalid (flash_rvalid),
  .sample_valid (sample_valid)
);

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic CLK_50M,
  output logic arst_n
);

  // 20 ns period
  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // Reset held for 3 cycles, released on a falling edge
  initial
  begin
    arst_n = 1'b0;
    repeat (3) @(posedge CLK_50M);
    @(negedge CLK_50M);
    arst_n = 1'b1;
  end

endmodule

//--- ipod_tb.sv
`timescale 1ns/1ps
`include "ipod_defines.svh"

module ipod_tb;

  localparam int MAX_LINES = 64;

  logic                 CLK_50M;
  logic                 arst_n;
  ipod_pkg::key_t       keys;
  ipod_pkg::play_sw_t   play_sw;
  logic                 flash_read;
  logic [`FLASH_AW-1:0] flash_addr;
  logic                 flash_wait;
  logic [`FLASH_DW-1:0] flash_rdata;
  logic                 flash_rvalid;
  ipod_pkg::sample_t    sample;
  logic                 sample_valid;
  logic [7:0]           led;
  ipod_pkg::seg_t       hex0, hex1, hex2, hex3, hex4, hex5;

  logic [31:0] stim [4*MAX_LINES];
  int          errors, checks, tests, samples_seen, cycles;
  int          limit = 1000000;
  logic [31:0] ref_n;
  int          ref_div;
  logic        ref_pause, ref_rev;
  int          win_cnt, win_peak;
  logic        led_due;
  logic [7:0]  led_exp;
  int          fl_state, fl_wait, fl_delay;
  logic [`FLASH_AW-1:0] fl_addr;

  tb_clk_gen u_clk_gen (.CLK_50M(CLK_50M), .arst_n(arst_n));

  ipod_top u_dut (
    .CLK_50M(CLK_50M), .arst_n(arst_n), .keys(keys), .play_sw(play_sw),
    .flash_read(flash_read), .flash_addr(flash_addr), .flash_wait(flash_wait),
    .flash_rdata(flash_rdata), .flash_rvalid(flash_rvalid),
    .sample(sample), .sample_valid(sample_valid), .led(led),
    .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
  );

  // Byte k of word A is (4A + k) mod 256
  function automatic logic [31:0] word_at(input logic [`FLASH_AW-1:0] a);
    logic [31:0] w;
    for (int k = 0; k < ipod_pkg::BYTES_PER_WORD; k++)
      w[8*k +: 8] = 8'(4 * a + k);
    return w;
  endfunction

  // Lit segments, bit 0 is a
  function automatic logic [6:0] lit_segments(input logic [3:0] nib);
    logic [6:0] t [16];
    t = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
          7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};
    return t[nib];
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic press_keys(input int mask, input int hold);
    int n_evt;
    n_evt = 1 + (hold - 1) / `KEY_REPEAT;
    keys = ipod_pkg::key_t'(mask[2:0]);
    repeat (hold) @(negedge CLK_50M);
    keys = '0;
    repeat (12) @(negedge CLK_50M);
    for (int e = 0; e < n_evt; e++)
    begin
      if (mask[0])
        ref_div = `DIV_DEFAULT;
      else if (mask[2])
        ref_div = (ref_div - `DIV_STEP < `DIV_MIN) ? `DIV_MIN : ref_div - `DIV_STEP;
      else if (mask[1])
        ref_div = (ref_div + `DIV_STEP > `DIV_MAX) ? `DIV_MAX : ref_div + `DIV_STEP;
    end
  endtask

  // Change switches just after a sample, well clear of the next tick
  task automatic set_switches(input int p, input int r);
    int target;
    target = samples_seen + 1;
    if (!ref_pause)
      while (samples_seen < target)
        @(posedge CLK_50M);
    @(negedge CLK_50M);
    play_sw.pause   = p[0];
    play_sw.reverse = r[0];
    ref_pause = p[0];
    ref_rev   = r[0];
  endtask

  task automatic run_samples(input int cnt);
    int target;
    target = samples_seen + cnt;
    while (samples_seen < target)
      @(posedge CLK_50M);
    @(negedge CLK_50M);
  endtask

  task automatic expect_divisor(input logic [31:0] v);
    logic [6:0] digits [6];
    digits = '{hex0, hex1, hex2, hex3, hex4, hex5};
    check_equal(ref_div, v, "divisor model");
    for (int d = 0; d < 6; d++)
      check_equal({25'h0, digits[d]}, {25'h0, ~lit_segments(v[4*d +: 4])}, "hex digit");
  endtask

  // ==================================================
  // Flash model with random wait and data delay
  // ==================================================
  initial
  begin
    void'($urandom(32'h79fc));
    forever
    begin
      @(negedge CLK_50M);
      flash_rvalid <= 1'b0;
      case (fl_state)
        0:
          if (flash_read)
          begin
            fl_addr  = flash_addr;
            fl_wait  = $urandom % 4;
            fl_delay = $urandom % 3 + 1;
            flash_wait <= (fl_wait != 0);
            fl_state = (fl_wait == 0) ? 2 : 1;
          end
        1:
        begin
          fl_wait--;
          if (fl_wait == 0)
          begin
            flash_wait <= 1'b0;
            fl_state = 2;
          end
        end
        default:
        begin
          flash_wait <= 1'b1;
          fl_delay--;
          if (fl_delay == 0)
          begin
            flash_rvalid <= 1'b1;
            flash_rdata  <= word_at(fl_addr);
            fl_state = 0;
          end
        end
      endcase
    end
  end

  // Sample and meter monitor
  always @(negedge CLK_50M)
  begin
    int v;
    if (arst_n)
    begin
      if (led_due)
      begin
        check_equal({24'h0, led}, {24'h0, led_exp}, "led bar after window");
        led_due = 1'b0;
      end
      if (sample_valid)
      begin
        if (ref_pause)
        begin
          errors++;
          $display("A sample was played while playback was paused, at %0d ns", $time);
        end
        check_equal({24'h0, sample}, {24'h0, ref_n[7:0]}, "sample value");
        v = $signed(ref_n[7:0]);
        if (v < 0)
          v = -v;
        if (v > win_peak)
          win_peak = v;
        win_cnt++;
        if (win_cnt == `VOL_WINDOW)
        begin
          led_exp  = 8'((1 << ((win_peak / 16 > 8) ? 8 : win_peak / 16)) - 1);
          led_due  = 1'b1;
          win_cnt  = 0;
          win_peak = 0;
        end
        samples_seen++;
        ref_n = ref_rev ? ref_n - 1 : ref_n + 1;
      end
    end
  end

  always @(posedge CLK_50M)
  begin
    cycles++;
    if (cycles > limit)
    begin
      $display("Timeout: the run went past %0d cycles", limit);
      $display("Checks failed");
      $finish;
    end
  end

  // ==================================================
  // File-driven test sequence
  // ==================================================
  initial
  begin
    int i;
    int cur;
    int err0;
    logic [31:0] op, a, b;
    keys = '0;
    play_sw = '0;
    flash_wait = 1'b1;
    flash_rvalid = 1'b0;
    flash_rdata = '0;
    {errors, checks, tests, samples_seen, cycles, fl_state, win_cnt, win_peak} = '0;
    ref_n = '0;
    ref_div = `DIV_DEFAULT;
    {ref_pause, ref_rev, led_due} = '0;
    for (i = 0; i < 4 * MAX_LINES; i++)
      stim[i] = '0;
    $readmemh("ipod_input.txt", stim);
    limit = 1000;
    for (i = 0; i < MAX_LINES && stim[4*i] != 0; i++)
      case (stim[4*i+1])
        1: limit += stim[4*i+3] + 20;
        2: limit += 2 * `DIV_MAX;
        3: limit += (stim[4*i+2] + 1) * `DIV_MAX;
        5: limit += stim[4*i+2];
        default: limit += 10;
      endcase
    // Reset is released on a falling edge, first entries see reset values
    @(posedge arst_n);
    cur = 0;
    err0 = 0;
    for (i = 0; i < MAX_LINES && stim[4*i] != 0; i++)
    begin
      op = stim[4*i+1];
      a  = stim[4*i+2];
      b  = stim[4*i+3];
      if (stim[4*i] != cur)
      begin
        if (cur != 0)
          $display("Test %0d finished with %0d errors", cur, errors - err0);
        cur  = stim[4*i];
        err0 = errors;
        tests++;
      end
      case (op)
        1: press_keys(a, b);
        2: set_switches(a, b);
        3: run_samples(a);
        4: expect_divisor(a);
        5: repeat (a) @(negedge CLK_50M);
        6:
        begin
          check_equal({24'h0, led}, a, "led after reset");
          check_equal({31'h0, sample_valid}, 0, "sample_valid after reset");
        end
        default:
        begin
          errors++;
          $display("Unknown operation %0d on entry %0d of the input file", op, i);
        end
      endcase
    end
    if (cur != 0)
      $display("Test %0d finished with %0d errors", cur, errors - err0);
    errors += u_dut.u_flash_reader.u_chk.fail_cnt;
    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

//--- sim.f
+incdir+.
ipod_pkg.sv
input_sync.sv
speed_ctrl.sv
flash_reader.sv
volume_meter.sv
hex_display.sv
ipod_top.sv
ipod_chk.sv
tb_clk_gen.sv
ipod_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run; pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module ipod_tb \
  -f sim.f -o ipod_sim \
  && ./obj_dir/ipod_sim | tee /dev/stderr | grep -q "All checks passed" \
  && echo "RESULT: PASS" \
  || { echo "RESULT: FAIL"; exit 1; }

//--- ipod_input.txt
// Columns in hex: test op arg1 arg2
// op 1 keys(mask up=4 down=2 rst=1, hold cycles), 2 switches(pause, reverse),
// op 3 run samples, 4 expect divisor, 5 idle cycles, 6 expect led after reset
1 6 0 0
1 4 28 0
2 1 4 a
2 4 20 0
2 1 4 a
2 1 4 a
2 1 4 a
2 4 10 0
2 1 1 a
2 4 28 0
2 1 2 258
2 4 60 0
2 1 1 a
2 4 28 0
3 3 20 0
4 2 0 1
4 3 20 0
5 2 1 1
5 5 c8 0
5 2 0 0
5 3 10 0
6 3 18 0
